/* sources.f */
bus_pkg.sv
panel_pkg.sv
bus_if.sv
bus_decoder.sv
mem_slave.sv
led_slave.sv
status_panel.sv
soc_top.sv
tb_soc_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_soc_top
FILELIST = sources.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;
    import bus_pkg::*;
    import panel_pkg::*;

    typedef enum logic [1:0] {op_write, op_read, op_up, op_down} op_e;

    typedef struct {
        string name;
        op_e   op;
        word_t addr;
        word_t data;
        sel_t  sel;
        logic  exp_err;
        word_t exp_data; // read data, or the panel byte before inversion
        page_t exp_page;
    } entry_t;

    localparam int timeout_cycles = 40;

    logic                 sys_clk;
    logic                 reset;
    word_t                wb_adr;
    word_t                wb_dat_w;
    sel_t                 wb_sel;
    logic                 wb_we;
    logic                 wb_cyc;
    logic                 wb_stb;
    word_t                wb_dat_r;
    logic                 wb_ack;
    logic                 wb_err;
    logic [btn_width-1:0] btn;
    logic [7:0]           led8;
    logic [3:0]           led4;

    // reference model, advanced while the table is built
    entry_t               table_q [$];
    word_t                mem_m [mem_words];
    word_t                mem_addr [4];
    logic [7:0]           led_m;
    logic [btn_width-1:0] btn_m;
    count_t               wr_m;
    count_t               rd_m;
    count_t               err_m;
    region_t              region_m;
    page_t                page_m;

    soc_top soc_top_inst (.*);

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_page(input string name, input page_t expected, input page_t actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // response kind as {ack, err}
    task automatic check_resp(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    function automatic logic [7:0] panel_byte(input page_t p);
        case (p)
            page_led:    return led_m;
            page_writes: return wr_m;
            page_reads:  return rd_m;
            page_errors: return err_m;
            page_region: return {4'h0, region_m};
            3'd5:        return pattern_a;
            3'd6:        return pattern_b;
            default:     return pattern_c;
        endcase
    endfunction

    task automatic add_entry(input string name, input op_e op, input word_t addr,
                             input word_t data, input sel_t sel);
        entry_t                     e;
        region_t                    r;
        logic [mem_index_width-1:0] idx;
        r = addr[31:28];
        idx = addr[11:2]; // 4 KiB alias
        e.name = name;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.sel = sel;
        e.exp_err = 1'b0;
        e.exp_data = '0;
        if (op == op_up) begin
            page_m = page_m + 3'd1; // 7 wraps to 0
            btn_m = 2'b01;
        end else if (op == op_down) begin
            page_m = page_m - 3'd1;
            btn_m = 2'b10;
        end else if (r != region_mem && r != region_led) begin
            e.exp_err = 1'b1;
            err_m = err_m + 8'd1;
        end else if (op == op_write) begin
            wr_m = wr_m + 8'd1;
            if (r == region_mem) begin
                for (int i = 0; i < sel_width; i++) begin
                    if (sel[i]) begin
                        mem_m[idx][8*i +: 8] = data[8*i +: 8];
                    end
                end
            end else if (addr[27:2] == 26'd0 && sel[0]) begin
                led_m = data[7:0];
            end
        end else begin
            rd_m = rd_m + 8'd1;
            if (r == region_mem) begin
                e.exp_data = mem_m[idx];
            end else if (addr[27:2] == 26'd0) begin
                e.exp_data = {24'h0, led_m};
            end else if (addr[27:2] == 26'd1) begin
                e.exp_data = {30'h0, btn_m};
            end
        end
        if (op == op_write || op == op_read) begin
            region_m = r;
        end else begin
            e.exp_data = {24'h0, panel_byte(page_m)};
        end
        e.exp_page = page_m;
        table_q.push_back(e);
    endtask

    task automatic run_reset();
        repeat (4) @(posedge sys_clk);
        reset <= 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        int         cycles;
        logic [1:0] resp;
        word_t      rd;
        logic [3:0] led4_before;
        cycles = 0;
        resp = 2'b00;
        rd = '0;
        @(posedge sys_clk);
        if (e.op == op_up || e.op == op_down) begin
            led4_before = led4;
            btn <= '0; // release so the press is a fresh edge
            @(posedge sys_clk);
            btn <= (e.op == op_up) ? 2'b01 : 2'b10;
            @(negedge sys_clk);
            while (led4 == led4_before) begin
                cycles++;
                if (cycles > timeout_cycles) begin
                    fail_stop($sformatf("led4 never moved off page %0d after %s",
                                        led4_before, e.name));
                end
                @(negedge sys_clk);
            end
            check_page(e.name, e.exp_page, led4[2:0]);
            if (led4[3] !== 1'b0) begin
                fail_stop($sformatf("Fail %s: expected led4 bit 3 0, actual %b",
                                    e.name, led4[3]));
            end
            check_byte(e.name, ~e.exp_data[7:0], led8);
        end else begin
            wb_adr <= e.addr;
            wb_dat_w <= e.data;
            wb_sel <= e.sel;
            wb_we <= (e.op == op_write);
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            while (resp == 2'b00) begin
                @(negedge sys_clk);
                resp = {wb_ack, wb_err};
                rd = wb_dat_r;
                cycles++;
                if (resp == 2'b00 && cycles > timeout_cycles) begin
                    fail_stop($sformatf("no ack or err came back for %s", e.name));
                end
            end
            @(posedge sys_clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            check_resp(e.name, e.exp_err ? 2'b01 : 2'b10, resp);
            if (e.op == op_read && !e.exp_err) begin
                check_word(e.name, e.exp_data, rd);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        wb_we = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        btn = '0;
        void'($urandom(30736));
        led_m = '0;
        btn_m = '0;
        wr_m = '0;
        rd_m = '0;
        err_m = '0;
        region_m = '0;
        page_m = page_led;

        for (int i = 0; i < 4; i++) begin
            mem_addr[i] = word_t'(($urandom % 1024) * 4);
            add_entry($sformatf("mem_fill_%0d", i), op_write, mem_addr[i], $urandom, 4'hF);
        end
        for (int i = 0; i < 4; i++) begin
            // never all four lanes
            add_entry($sformatf("mem_partial_%0d", i), op_write, mem_addr[i], $urandom,
                      sel_t'($urandom % 15));
            add_entry($sformatf("mem_read_%0d", i), op_read, mem_addr[i], '0, 4'hF);
        end
        add_entry("mem_alias_4k", op_read, mem_addr[0] + 32'h1000, '0, 4'hF);
        add_entry("mem_alias_12k", op_read, mem_addr[1] + 32'h3000, '0, 4'hF);
        add_entry("first_up", op_up, '0, '0, '0);
        add_entry("led_write", op_write, 32'h2000_0000, $urandom, 4'hF);
        add_entry("led_read", op_read, 32'h2000_0000, '0, 4'hF);
        add_entry("led_write_no_sel0", op_write, 32'h2000_0000, $urandom, 4'hE);
        add_entry("led_read_kept", op_read, 32'h2000_0000, '0, 4'hF);
        add_entry("btn_read", op_read, 32'h2000_0004, '0, 4'hF);
        add_entry("led_hole_read", op_read, 32'h2000_0010, '0, 4'hF);
        add_entry("region1_write", op_write, 32'h1000_0000 | mem_addr[0], $urandom, 4'hF);
        add_entry("region3_read", op_read, 32'h3000_0000, '0, 4'hF);
        add_entry("region7_write", op_write, 32'h7000_0000 | mem_addr[1], $urandom, 4'hF);
        add_entry("mem_after_err_0", op_read, mem_addr[0], '0, 4'hF);
        add_entry("mem_after_err_1", op_read, mem_addr[1], '0, 4'hF);
        add_entry("region7_read", op_read, 32'h7000_0004, '0, 4'hF);
        add_entry("down_to_0", op_down, '0, '0, '0);
        add_entry("down_wrap", op_down, '0, '0, '0);
        add_entry("up_wrap", op_up, '0, '0, '0);
        for (int p = 1; p < page_count; p++) begin
            add_entry($sformatf("up_to_page_%0d", p), op_up, '0, '0, '0);
        end

        run_reset();
        @(negedge sys_clk);
        check_resp("after_reset", 2'b00, {wb_ack, wb_err});
        check_page("after_reset", page_led, led4[2:0]);
        check_byte("after_reset", 8'hFF, led8);
        foreach (table_q[k]) begin
            apply_entry(table_q[k]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input logic sys_clk,
    input logic reset,
    input logic [bus_pkg::addr_width-1:0] wb_adr,
    input logic [bus_pkg::data_width-1:0] wb_dat_w,
    input logic [bus_pkg::sel_width-1:0] wb_sel,
    input logic wb_we,
    input logic wb_cyc,
    input logic wb_stb,
    output logic [bus_pkg::data_width-1:0] wb_dat_r,
    output logic wb_ack,
    output logic wb_err,
    input logic [panel_pkg::btn_width-1:0] btn,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    wb_if host_bus ();
    wb_if mem_bus ();
    wb_if led_bus ();
    bus_status_if status_bus ();

    logic [7:0] led_value; // led register toward the panel

    // host pins onto the internal bus
    assign host_bus.adr.flat = wb_adr;
    assign host_bus.dat_w = wb_dat_w;
    assign host_bus.sel = wb_sel;
    assign host_bus.we = wb_we;
    assign host_bus.cyc = wb_cyc;
    assign host_bus.stb = wb_stb;
    assign wb_dat_r = host_bus.dat_r;
    assign wb_ack = host_bus.ack;
    assign wb_err = host_bus.err;

    bus_decoder u_bus_decoder (
        .sys_clk (sys_clk   ),
        .reset   (reset     ),
        .host    (host_bus  ),
        .mem     (mem_bus   ),
        .led     (led_bus   ),
        .status  (status_bus)
    );

    mem_slave u_mem_slave (
        .sys_clk (sys_clk),
        .reset   (reset  ),
        .bus     (mem_bus)
    );

    led_slave u_led_slave (
        .sys_clk   (sys_clk  ),
        .reset     (reset    ),
        .bus       (led_bus  ),
        .btn       (btn      ),
        .led_value (led_value)
    );

    status_panel u_status_panel (
        .sys_clk   (sys_clk   ),
        .reset     (reset     ),
        .btn       (btn       ),
        .led_value (led_value ),
        .status    (status_bus),
        .led8      (led8      ),
        .led4      (led4      )
    );

endmodule

/* status_panel.sv */
`timescale 1ns/1ps

module status_panel (
    input logic sys_clk,
    input logic reset,
    input logic [panel_pkg::btn_width-1:0] btn,
    input logic [7:0] led_value,
    bus_status_if.sink status,
    output logic [7:0] led8,
    output logic [3:0] led4
);
    import panel_pkg::*;

    logic [btn_width-1:0] btn_meta;
    logic [btn_width-1:0] btn_sync;
    logic [btn_width-1:0] btn_prev;
    logic [btn_width-1:0] btn_rise;
    page_t                page;
    logic [7:0]           shown;

    assign btn_rise = btn_sync & ~btn_prev;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            page <= page_led;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            if (btn_rise[0] && !btn_rise[1]) begin // up
                page <= (page == page_t'(page_count - 1)) ? '0 : page + page_t'(1);
            end else if (btn_rise[1] && !btn_rise[0]) begin // down
                page <= (page == '0) ? page_t'(page_count - 1) : page - page_t'(1);
            end
        end
    end

    always_comb begin
        case (page)
            page_led:    shown = led_value;
            page_writes: shown = status.wr_count;
            page_reads:  shown = status.rd_count;
            page_errors: shown = status.err_count;
            page_region: shown = 8'(status.last_region);
            3'd5:        shown = pattern_a;
            3'd6:        shown = pattern_b;
            default:     shown = pattern_c;
        endcase
    end

    // leds are active low, page digit active high
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            led8 <= '1;
            led4 <= '0;
        end else begin
            led8 <= ~shown;
            led4 <= 4'(page);
        end
    end

    page_in_range: assert property (
        @(posedge sys_clk) disable iff (reset) led4 < 4'(page_count)
    );

endmodule

/* led_slave.sv */
`timescale 1ns/1ps

module led_slave (
    input logic sys_clk,
    input logic reset,
    wb_if.slave bus,
    input logic [panel_pkg::btn_width-1:0] btn,
    output logic [7:0] led_value
);
    import bus_pkg::*;
    import panel_pkg::*;

    logic [btn_width-1:0]        btn_meta;
    logic [btn_width-1:0]        btn_sync;
    logic [word_index_width-1:0] word;
    logic                        req;
    logic                        ack_q;
    word_t                       rd_q;

    assign word = bus.adr.field.offset[offset_width-1:2];
    assign req = bus.cyc && bus.stb;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            btn_meta <= '0;
            btn_sync <= '0;
            ack_q <= 1'b0;
            led_value <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            ack_q <= req && !ack_q;
            if (req && !ack_q && bus.we && bus.sel[0] && word == led_reg_word) begin
                led_value <= bus.dat_w[7:0];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (req && !ack_q) begin
            case (word)
                led_reg_word: rd_q <= word_t'(led_value);
                btn_word:     rd_q <= word_t'(btn_sync);
                default:      rd_q <= '0; // hole in the window
            endcase
        end
    end

    assign bus.dat_r = rd_q;
    assign bus.ack = ack_q;
    assign bus.err = 1'b0;

endmodule

/* mem_slave.sv */
`timescale 1ns/1ps

module mem_slave (
    input logic sys_clk,
    input logic reset,
    wb_if.slave bus
);
    import bus_pkg::*;

    word_t                      mem_q [mem_words];
    word_t                      rd_q;
    logic [mem_index_width-1:0] index;
    logic                       req;
    logic                       ack_q;

    // word index from offset bits 11:2, so the window aliases every 4 KiB
    assign index = bus.adr.flat[mem_index_width+1:2];
    assign req = bus.cyc && bus.stb;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q; // low again after each ack
        end
    end

    always_ff @(posedge sys_clk) begin
        if (req && !ack_q) begin
            if (bus.we) begin
                for (int i = 0; i < sel_width; i++) begin
                    if (bus.sel[i]) begin
                        mem_q[index][8*i +: 8] <= bus.dat_w[8*i +: 8];
                    end
                end
            end
            rd_q <= mem_q[index]; // held through the ack cycle
        end
    end

    assign bus.dat_r = rd_q;
    assign bus.ack = ack_q;
    assign bus.err = 1'b0; // every word exists

    ack_follows_req: assert property (
        @(posedge sys_clk) disable iff (reset)
        bus.ack |-> $past(bus.cyc && bus.stb)
    );

endmodule

/* bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
    input logic sys_clk,
    input logic reset,
    wb_if.slave host,
    wb_if.master mem,
    wb_if.master led,
    bus_status_if.source status
);
    import bus_pkg::*;

    region_t region;
    logic    hit_mem;
    logic    hit_led;
    logic    hit_none;
    logic    req;
    logic    err_q;
    logic    resp_ack;
    logic    resp_err;

    assign region = host.adr.field.region;
    assign hit_mem = (region == region_mem);
    assign hit_led = (region == region_led);
    // old jtag window, default window and everything above
    assign hit_none = (region == region_jtag) || (region == region_default) ||
                      (region > region_default);
    assign req = host.cyc && host.stb;

    // payload goes to both slaves, only the strobes are steered
    assign mem.adr = host.adr;
    assign mem.dat_w = host.dat_w;
    assign mem.sel = host.sel;
    assign mem.we = host.we;
    assign mem.cyc = host.cyc && hit_mem;
    assign mem.stb = host.stb && hit_mem;

    assign led.adr = host.adr;
    assign led.dat_w = host.dat_w;
    assign led.sel = host.sel;
    assign led.we = host.we;
    assign led.cyc = host.cyc && hit_led;
    assign led.stb = host.stb && hit_led;

    // response mux
    always_comb begin
        if (hit_mem) begin
            host.dat_r = mem.dat_r;
        end else if (hit_led) begin
            host.dat_r = led.dat_r;
        end else begin
            host.dat_r = '0;
        end
    end

    assign resp_ack = (hit_mem && mem.ack) || (hit_led && led.ack);
    assign resp_err = err_q || (hit_mem && mem.err) || (hit_led && led.err);
    assign host.ack = resp_ack;
    assign host.err = resp_err;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            err_q <= 1'b0;
            status.wr_count <= '0;
            status.rd_count <= '0;
            status.err_count <= '0;
            status.last_region <= '0;
        end else begin
            err_q <= req && hit_none && !err_q; // one cycle, like a slave ack
            if (resp_ack && host.we) begin
                status.wr_count <= status.wr_count + count_t'(1);
            end
            if (resp_ack && !host.we) begin
                status.rd_count <= status.rd_count + count_t'(1);
            end
            if (resp_err) begin
                status.err_count <= status.err_count + count_t'(1);
            end
            if (resp_ack || resp_err) begin
                status.last_region <= region;
            end
        end
    end

    // slave acks and the local error path must never meet
    ack_err_exclusive: assert property (
        @(posedge sys_clk) disable iff (reset) !(host.ack && host.err)
    );

endmodule

/* bus_if.sv */
`timescale 1ns/1ps

interface wb_if;
    import bus_pkg::*;

    addr_u adr;
    word_t dat_w;
    word_t dat_r;
    sel_t  sel;
    logic  we;
    logic  cyc;
    logic  stb;
    logic  ack;
    logic  err;

    modport master (
        output adr, dat_w, sel, we, cyc, stb,
        input  dat_r, ack, err
    );

    modport slave (
        input  adr, dat_w, sel, we, cyc, stb,
        output dat_r, ack, err
    );

endinterface

// decoder counters toward the status panel
interface bus_status_if;
    import bus_pkg::*;

    count_t  wr_count;
    count_t  rd_count;
    count_t  err_count;
    region_t last_region;

    modport source (
        output wr_count, rd_count, err_count, last_region
    );

    modport sink (
        input wr_count, rd_count, err_count, last_region
    );

endinterface

/* panel_pkg.sv */
package panel_pkg;

    localparam int page_count = 8;
    typedef logic [2:0] page_t;

    localparam page_t page_led = 3'd0;
    localparam page_t page_writes = 3'd1;
    localparam page_t page_reads = 3'd2;
    localparam page_t page_errors = 3'd3;
    localparam page_t page_region = 3'd4;

    // fixed lamp test bytes on the top three pages
    localparam logic [7:0] pattern_a = 8'hAA;
    localparam logic [7:0] pattern_b = 8'h55;
    localparam logic [7:0] pattern_c = 8'hF0;

    localparam int btn_width = 2; // up, down

endpackage

/* bus_pkg.sv */
package bus_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int sel_width = 4;

    localparam int region_width = 4;
    localparam int offset_width = addr_width - region_width;
    localparam int word_index_width = offset_width - 2; // offset without byte lane bits

    typedef logic [data_width-1:0] word_t;
    typedef logic [sel_width-1:0] sel_t;
    typedef logic [region_width-1:0] region_t;
    typedef logic [7:0] count_t;

    // one address, seen flat by the host and memory, split by the decoder
    typedef union packed {
        logic [addr_width-1:0] flat;
        struct packed {
            region_t                 region;
            logic [offset_width-1:0] offset;
        } field;
    } addr_u;

    // 256 MiB windows
    localparam region_t region_mem = 4'd0;
    localparam region_t region_jtag = 4'd1; // unmapped
    localparam region_t region_led = 4'd2;
    localparam region_t region_default = 4'd3;

    localparam int mem_words = 1024;
    localparam int mem_index_width = 10; // offset bits 11:2

    // word offsets inside the led window
    localparam logic [word_index_width-1:0] led_reg_word = word_index_width'(0);
    localparam logic [word_index_width-1:0] btn_word = word_index_width'(1);

endpackage
